// File: hdl/msx_io_params.svh
`ifndef MSX_IO_PARAMS_SVH
`define MSX_IO_PARAMS_SVH

// ================================================
// SD bus activity
// ================================================

// Quiet cycles before the activity flag drops
`define SD_ACT_HOLD 1000000

// Byte shifted out while only reading
`define SPI_FILL_BYTE 8'hFF

// ================================================
// Scaler aspect terms
// ================================================

`define AR_ORIG_X 12'd400
// Narrower 4:3 for the 200 line crops
`define AR_WIDE_X 12'd340
`define AR_ORIG_Y 12'd300

// 4:3 monitors at or above this width still crop
`define HDMI_TALL_MIN_W 12'd1440

// Crop line counts
`define CROP_240 10'd240
`define CROP_256 10'd256
`define CROP_200 10'd200
`define CROP_216 10'd216

`endif

// File: hdl/msx_io_pkg.sv
package msx_io_pkg;

   // ================================================
   // Vector types
   // ================================================

   // One byte on the SPI bus
   typedef logic [7:0] spi_byte_t;

   // HDMI width in pixels or height in lines
   typedef logic [11:0] hdmi_dim_t;

   // One aspect ratio term for the scaler
   typedef logic [11:0] aspect_t;

   // Visible line count after vertical crop
   typedef logic [9:0] crop_t;

   // ================================================
   // Grouped signals
   // ================================================

   // Video settings from the menu
   // aspect_sel 0 original, 1 full screen, 2/3 custom
   typedef struct packed {
      logic [1:0] aspect_sel;
      logic [1:0] scanlines;
      logic       vcrop_en;
   } video_cfg_t;

   // Outgoing SPI pins toward one card
   typedef struct packed {
      logic sck;
      logic mosi;
      logic cs_n;
   } sd_pins_t;

endpackage

// File: hdl/spi_byte_engine.sv
`timescale 1ns/100ps

`include "msx_io_params.svh"

module spi_byte_engine (
   input  logic                  clk21m,
   input  logic                  reset,
   input  logic                  tx,
   input  logic                  rx,
   input  msx_io_pkg::spi_byte_t din,
   output msx_io_pkg::spi_byte_t dout,
   output logic                  ready,
   output logic                  spi_clk,
   input  logic                  spi_miso,
   output logic                  spi_mosi
);

   // Bit 4 set means idle, bits 3:0 count half periods
   logic [4:0] counter;
   // Shift register, MSB goes out first
   msx_io_pkg::spi_byte_t io_byte;
   // Byte received by the previous transfer
   msx_io_pkg::spi_byte_t data;

   // Idle flag doubles as ready
   assign ready = counter[4];
   // Odd counts are the high phase
   assign spi_clk = counter[0];
   assign spi_mosi = io_byte[7];
   assign dout = data;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         counter <= 5'b10000;
         io_byte <= `SPI_FILL_BYTE;
         data <= '0;
      end else if (counter[4]) begin
         // Start only from idle
         if (tx | rx) begin
            counter <= 5'd0;
            // Hand over the last received byte
            data <= io_byte;
            io_byte <= tx ? din : `SPI_FILL_BYTE;
         end
      end else begin
         // Sample MISO while the clock is high
         if (counter[0]) begin
            io_byte <= {io_byte[6:0], spi_miso};
         end
         // Wraps into idle after 16 steps
         counter <= counter + 5'd1;
      end
   end

endmodule

// File: hdl/sd_port_switch.sv
`timescale 1ns/100ps

`include "msx_io_params.svh"

module sd_port_switch #(
   parameter int HOLD_CYCLES = `SD_ACT_HOLD
) (
   input  logic                 clk21m,
   input  logic                 reset,
   input  logic                 img_mounted,
   input  logic [31:0]          img_size,
   input  logic                 spi_clk,
   input  logic                 spi_mosi,
   input  logic                 sd_ss_n,
   output logic                 spi_miso,
   output msx_io_pkg::sd_pins_t phys_sd,
   input  logic                 phys_miso,
   output logic                 vsd_ss_n,
   input  logic                 vsd_miso,
   output logic                 sd_act
);

   // Wide enough to hold HOLD_CYCLES itself
   localparam int QW = $clog2(HOLD_CYCLES + 1);

   logic          vsd_sel;
   logic          old_mosi;
   logic          old_miso;
   logic          bus_change;
   logic [QW-1:0] quiet;

   // ================================================
   // Card selection
   // ================================================

   // Mount event decides the card, empty image means physical
   always_ff @(posedge clk21m) begin
      if (reset) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical pins parked while the image is in use
   assign phys_sd.cs_n = sd_ss_n | vsd_sel;
   assign phys_sd.sck = spi_clk & ~vsd_sel;
   assign phys_sd.mosi = spi_mosi & ~vsd_sel;

   // Virtual card only sees select when chosen
   assign vsd_ss_n = sd_ss_n | ~vsd_sel;

   // Return path from the chosen card
   assign spi_miso = vsd_sel ? vsd_miso : phys_miso;

   // ================================================
   // Activity detector
   // ================================================

   // Previous line values, tracked during reset too
   always_ff @(posedge clk21m) begin
      old_mosi <= spi_mosi;
      old_miso <= spi_miso;
   end

   // Any toggle on either data line
   assign bus_change = (old_mosi ^ spi_mosi) | (old_miso ^ spi_miso);

   // Counter saturates at HOLD_CYCLES, flag high until then
   always_ff @(posedge clk21m) begin
      if (reset) begin
         quiet <= QW'(HOLD_CYCLES);
         sd_act <= 1'b0;
      end else if (bus_change) begin
         quiet <= '0;
         sd_act <= 1'b1;
      end else if (quiet < QW'(HOLD_CYCLES)) begin
         quiet <= quiet + 1'b1;
         sd_act <= 1'b1;
      end else begin
         sd_act <= 1'b0;
      end
   end

endmodule

// File: hdl/video_crop.sv
`timescale 1ns/100ps

`include "msx_io_params.svh"

module video_crop (
   input  logic                   clk21m,
   input  logic                   reset,
   input  msx_io_pkg::hdmi_dim_t  hdmi_width,
   input  msx_io_pkg::hdmi_dim_t  hdmi_height,
   input  logic                   forced_scandoubler,
   input  msx_io_pkg::video_cfg_t cfg,
   output msx_io_pkg::aspect_t    arx,
   output msx_io_pkg::aspect_t    ary,
   output msx_io_pkg::crop_t      crop_size
);

   logic                scandoubler;
   logic                wide_screen;
   logic                tall_screen;
   logic [12:0]         height_x15;
   msx_io_pkg::crop_t   crop_lines;
   logic                wide;
   msx_io_pkg::aspect_t arx_next;
   msx_io_pkg::aspect_t ary_next;
   msx_io_pkg::crop_t   crop_next;

   // ================================================
   // Monitor classification
   // ================================================

   // Doubled output never gets cropped
   assign scandoubler = forced_scandoubler | (|cfg.scanlines);

   // Height times 1.5, one bit wider to avoid overflow
   assign height_x15 = {1'b0, hdmi_height} + {2'b00, hdmi_height[11:1]};

   // Widescreen when width at least 1.5x height
   assign wide_screen = {1'b0, hdmi_width} >= height_x15;

   // Large 4:3 modes fail the ratio test
   assign tall_screen = hdmi_width >= `HDMI_TALL_MIN_W;

   // Line count by panel height
   always_comb begin
      crop_lines = '0;
      wide = 1'b0;
      if (!scandoubler) begin
         if (wide_screen) begin
            case (hdmi_height)
               12'd480: crop_lines = `CROP_240;
               12'd720: crop_lines = `CROP_240;
               12'd1200: crop_lines = `CROP_240;
               // 200 lines need the narrower aspect
               12'd600: begin
                  crop_lines = `CROP_200;
                  wide = cfg.vcrop_en;
               end
               12'd800: begin
                  crop_lines = `CROP_200;
                  wide = cfg.vcrop_en;
               end
               12'd768: crop_lines = `CROP_256;
               12'd1080: crop_lines = `CROP_216;
               default: crop_lines = '0;
            endcase
         end else if (tall_screen) begin
            // 1920x1440 and 2048x1536
            case (hdmi_height)
               12'd1440: crop_lines = `CROP_240;
               12'd1536: crop_lines = `CROP_256;
               default: crop_lines = '0;
            endcase
         end
      end
   end

   // ================================================
   // Scaler terms
   // ================================================

   // Crop only when enabled in the menu
   assign crop_next = cfg.vcrop_en ? crop_lines : '0;

   // Original aspect, else custom index passed down
   assign arx_next = (cfg.aspect_sel == 2'd0) ?
                     (wide ? `AR_WIDE_X : `AR_ORIG_X) :
                     msx_io_pkg::aspect_t'(cfg.aspect_sel) - 12'd1;
   assign ary_next = (cfg.aspect_sel == 2'd0) ? `AR_ORIG_Y : '0;

   // One register stage on every output
   always_ff @(posedge clk21m) begin
      if (reset) begin
         arx <= '0;
         ary <= '0;
         crop_size <= '0;
      end else begin
         arx <= arx_next;
         ary <= ary_next;
         crop_size <= crop_next;
      end
   end

endmodule

// File: hdl/msx_io_top.sv
`timescale 1ns/100ps

`include "msx_io_params.svh"

module msx_io_top #(
   parameter int HOLD_CYCLES = `SD_ACT_HOLD
) (
   input  logic                   clk21m,
   input  logic                   reset,

   // MSX core side of the SPI engine
   input  logic                   spi_tx,
   input  logic                   spi_rx,
   input  msx_io_pkg::spi_byte_t  spi_din,
   output msx_io_pkg::spi_byte_t  spi_dout,
   output logic                   spi_ready,
   input  logic                   sd_ss_n,

   // Image mount from the host
   input  logic                   img_mounted,
   input  logic [31:0]            img_size,

   // Physical card pins
   output msx_io_pkg::sd_pins_t   phys_sd,
   input  logic                   phys_miso,

   // Virtual card bus
   output logic                   vsd_sck,
   output logic                   vsd_mosi,
   output logic                   vsd_ss_n,
   input  logic                   vsd_miso,

   output logic                   sd_act,

   // Scaler geometry
   input  msx_io_pkg::hdmi_dim_t  hdmi_width,
   input  msx_io_pkg::hdmi_dim_t  hdmi_height,
   input  logic                   forced_scandoubler,
   input  msx_io_pkg::video_cfg_t video_cfg,
   output msx_io_pkg::aspect_t    arx,
   output msx_io_pkg::aspect_t    ary,
   output msx_io_pkg::crop_t      crop_size
);

   // Internal SPI bus
   logic spi_clk;
   logic spi_mosi;
   logic spi_miso;

   // ================================================
   // SD card path
   // ================================================

   spi_byte_engine u_spi (
      .clk21m   (clk21m),
      .reset    (reset),
      .tx       (spi_tx),
      .rx       (spi_rx),
      .din      (spi_din),
      .dout     (spi_dout),
      .ready    (spi_ready),
      .spi_clk  (spi_clk),
      .spi_miso (spi_miso),
      .spi_mosi (spi_mosi)
   );

   // Virtual card shares clock and data, select is gated
   assign vsd_sck = spi_clk;
   assign vsd_mosi = spi_mosi;

   sd_port_switch #(
      .HOLD_CYCLES (HOLD_CYCLES)
   ) u_switch (
      .clk21m      (clk21m),
      .reset       (reset),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .spi_clk     (spi_clk),
      .spi_mosi    (spi_mosi),
      .sd_ss_n     (sd_ss_n),
      .spi_miso    (spi_miso),
      .phys_sd     (phys_sd),
      .phys_miso   (phys_miso),
      .vsd_ss_n    (vsd_ss_n),
      .vsd_miso    (vsd_miso),
      .sd_act      (sd_act)
   );

   // ================================================
   // Video geometry
   // ================================================

   video_crop u_crop (
      .clk21m             (clk21m),
      .reset              (reset),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .cfg                (video_cfg),
      .arx                (arx),
      .ary                (ary),
      .crop_size          (crop_size)
   );

endmodule

// File: verif/msx_io_sva.sv
`timescale 1ns/100ps

module msx_io_sva (
   input logic                 clk21m,
   input logic                 reset,
   input logic                 ready,
   input logic                 spi_clk,
   input logic                 vsd_sel,
   input msx_io_pkg::sd_pins_t phys_sd
);

   // ================================================
   // SPI engine
   // ================================================

   // Ready back high exactly 16 cycles after it dropped
   property p_busy_len;
      @(posedge clk21m) disable iff (reset)
         $rose(ready) |-> (!$past(ready, 16) && $past(ready, 17));
   endproperty

   // SPI clock parked low between transfers
   property p_idle_clk;
      @(posedge clk21m) disable iff (reset)
         ready |-> !spi_clk;
   endproperty

   // ================================================
   // Physical card isolation
   // ================================================

   // Image in use, physical pins parked with cs_n high
   property p_phys_parked;
      @(posedge clk21m) disable iff (reset)
         vsd_sel |-> (phys_sd == 3'b001);
   endproperty

   a_busy_len: assert property (p_busy_len)
      else $error("SPI transfer length is not 16 cycles");
   a_idle_clk: assert property (p_idle_clk)
      else $error("SPI clock high while the engine is idle");
   a_phys_parked: assert property (p_phys_parked)
      else $error("Physical SD pins active while the image card is selected");

endmodule

// File: verif/msx_io_tb.sv
`timescale 1ns/100ps

`include "msx_io_params.svh"

module msx_io_tb;

   // Short hold so the activity flag drops quickly
   localparam int ACT_HOLD = 64;

   logic                   clk21m;
   logic                   reset;
   logic                   spi_tx;
   logic                   spi_rx;
   msx_io_pkg::spi_byte_t  spi_din;
   msx_io_pkg::spi_byte_t  spi_dout;
   logic                   spi_ready;
   logic                   sd_ss_n;
   logic                   img_mounted;
   logic [31:0]            img_size;
   msx_io_pkg::sd_pins_t   phys_sd;
   logic                   phys_miso;
   logic                   vsd_sck;
   logic                   vsd_mosi;
   logic                   vsd_ss_n;
   logic                   vsd_miso;
   logic                   sd_act;
   msx_io_pkg::hdmi_dim_t  hdmi_width;
   msx_io_pkg::hdmi_dim_t  hdmi_height;
   logic                   forced_scandoubler;
   msx_io_pkg::video_cfg_t video_cfg;
   msx_io_pkg::aspect_t    arx;
   msx_io_pkg::aspect_t    ary;
   msx_io_pkg::crop_t      crop_size;

   // Card model shift register and last seen SPI clock
   msx_io_pkg::spi_byte_t card_sr;
   logic                  prev_sck;
   // What the previous transfer should have received
   msx_io_pkg::spi_byte_t prev_card;
   logic                  have_prev;

   int value_errors;
   int other_errors;
   int line_no;

   msx_io_top #(.HOLD_CYCLES(ACT_HOLD)) DUT (.*);

   bind spi_byte_engine msx_io_sva u_spi_sva (
      .clk21m  (clk21m),
      .reset   (reset),
      .ready   (ready),
      .spi_clk (spi_clk),
      .vsd_sel (1'b0),
      .phys_sd (3'b001)
   );

   bind sd_port_switch msx_io_sva u_pin_sva (
      .clk21m  (clk21m),
      .reset   (reset),
      .ready   (1'b1),
      .spi_clk (1'b0),
      .vsd_sel (vsd_sel),
      .phys_sd (phys_sd)
   );

   always #50 clk21m = ~clk21m;

   task automatic report_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("[ERROR] %s (line %0d): expected %0h, actual %0h", what, line_no, expected,
               actual);
      value_errors++;
   endtask

   // Card model, next bit once a high SPI clock phase is over
   task automatic drive_card(input logic vsd);
      if (prev_sck && !vsd_sck) begin
         card_sr = {card_sr[6:0], 1'b0};
      end
      prev_sck = vsd_sck;
      // Unselected card answers inverted
      vsd_miso = vsd ? card_sr[7] : ~card_sr[7];
      phys_miso = vsd ? ~card_sr[7] : card_sr[7];
   endtask

   // ================================================
   // SPI byte transfer
   // ================================================

   task automatic run_spi(input logic is_tx, input msx_io_pkg::spi_byte_t tx_byte,
                          input msx_io_pkg::spi_byte_t card_byte, input logic vsd);
      msx_io_pkg::spi_byte_t exp_mosi;
      msx_io_pkg::spi_byte_t got_mosi;
      logic [2:0]            exp_pins;
      int                    busy;
      int                    wait_cnt;
      logic                  saw_act;
      exp_mosi = is_tx ? tx_byte : `SPI_FILL_BYTE;
      got_mosi = '0;
      busy = 0;
      wait_cnt = 0;
      saw_act = 1'b0;
      while (!spi_ready && wait_cnt < 40) begin
         @(negedge clk21m);
         wait_cnt++;
      end
      if (!spi_ready) begin
         $display("Timeout: SPI engine never became ready at line %0d", line_no);
         other_errors++;
         return;
      end
      // One cycle strobe, card presents its MSB
      spi_tx = is_tx;
      spi_rx = !is_tx;
      spi_din = tx_byte;
      card_sr = card_byte;
      prev_sck = 1'b0;
      drive_card(vsd);
      @(negedge clk21m);
      spi_tx = 1'b0;
      spi_rx = 1'b0;
      // Previous byte is handed over at this start
      if (have_prev && spi_dout !== prev_card) begin
         report_mismatch("spi_dout", 32'(prev_card), 32'(spi_dout));
      end
      while (!spi_ready && busy < 40) begin
         drive_card(vsd);
         // SPI clock high on odd steps
         if (vsd_sck !== busy[0]) begin
            report_mismatch("spi_sck", 32'(busy[0]), 32'(vsd_sck));
         end
         if (vsd_sck) begin
            got_mosi = {got_mosi[6:0], vsd_mosi};
         end
         // sck, mosi, cs_n
         exp_pins = vsd ? 3'b001 : {busy[0], exp_mosi[7 - busy / 2], sd_ss_n};
         if (phys_sd !== exp_pins) begin
            report_mismatch("phys_sd", 32'(exp_pins), 32'(phys_sd));
         end
         saw_act = saw_act | sd_act;
         busy++;
         @(negedge clk21m);
      end
      if (!spi_ready) begin
         $display("Timeout: SPI transfer at line %0d never finished", line_no);
         other_errors++;
      end
      if (busy != 16) begin
         report_mismatch("busy_cycles", 32'd16, busy);
      end
      if (got_mosi !== exp_mosi) begin
         report_mismatch("mosi_byte", 32'(exp_mosi), 32'(got_mosi));
      end
      if (!saw_act) begin
         report_mismatch("sd_act_during", 32'd1, 32'(saw_act));
      end
      prev_card = card_byte;
      have_prev = 1'b1;
   endtask

   // ================================================
   // Image mount and video crop
   // ================================================

   task automatic mount_image(input logic [31:0] size, input logic exp_vsd);
      img_mounted = 1'b1;
      img_size = size;
      @(negedge clk21m);
      img_mounted = 1'b0;
      // Select reaches only the chosen card
      if (phys_sd.cs_n !== exp_vsd) begin
         report_mismatch("phys_cs_n", 32'(exp_vsd), 32'(phys_sd.cs_n));
      end
      if (vsd_ss_n !== !exp_vsd) begin
         report_mismatch("vsd_ss_n", 32'(!exp_vsd), 32'(vsd_ss_n));
      end
      sd_ss_n = 1'b1;
      @(negedge clk21m);
      if ({vsd_ss_n, phys_sd.cs_n} !== 2'b11) begin
         report_mismatch("ss_n_released", 32'h3, 32'({vsd_ss_n, phys_sd.cs_n}));
      end
      sd_ss_n = 1'b0;
      @(negedge clk21m);
   endtask

   task automatic check_crop(input int w, input int h, input logic forced,
                             input logic [4:0] cfg, input int exp_arx, input int exp_ary,
                             input int exp_crop);
      hdmi_width = 12'(w);
      hdmi_height = 12'(h);
      forced_scandoubler = forced;
      video_cfg = msx_io_pkg::video_cfg_t'(cfg);
      // Registered outputs, one edge later
      @(negedge clk21m);
      if (arx !== 12'(exp_arx)) begin
         report_mismatch("arx", exp_arx, 32'(arx));
      end
      if (ary !== 12'(exp_ary)) begin
         report_mismatch("ary", exp_ary, 32'(ary));
      end
      if (crop_size !== 10'(exp_crop)) begin
         report_mismatch("crop_size", exp_crop, 32'(crop_size));
      end
   endtask

   // ================================================
   // Main sequence
   // ================================================

   initial begin
      int          fd;
      int          n;
      int          wait_cnt;
      string       line;
      string       body;
      byte         kind;
      int          dir;
      int          sel;
      int          w;
      int          h;
      int          forced;
      int          e_arx;
      int          e_ary;
      int          e_crop;
      logic [7:0]  tx_byte;
      logic [7:0]  card_byte;
      logic [31:0] size;
      logic [4:0]  cfg;
      clk21m = 1'b0;
      reset = 1'b1;
      spi_tx = 1'b0;
      spi_rx = 1'b0;
      spi_din = '0;
      sd_ss_n = 1'b0;
      img_mounted = 1'b0;
      img_size = '0;
      phys_miso = 1'b0;
      vsd_miso = 1'b0;
      hdmi_width = '0;
      hdmi_height = '0;
      forced_scandoubler = 1'b0;
      video_cfg = '0;
      card_sr = '0;
      prev_sck = 1'b0;
      prev_card = '0;
      have_prev = 1'b0;
      value_errors = 0;
      other_errors = 0;
      line_no = 0;
      repeat (3) @(negedge clk21m);
      reset = 1'b0;

      // Idle state after reset, physical card selected
      if (spi_ready !== 1'b1) report_mismatch("reset_ready", 32'd1, 32'(spi_ready));
      if (spi_dout !== 8'h00) report_mismatch("reset_dout", 32'd0, 32'(spi_dout));
      if (vsd_sck !== 1'b0) report_mismatch("reset_sck", 32'd0, 32'(vsd_sck));
      if (sd_act !== 1'b0) report_mismatch("reset_sd_act", 32'd0, 32'(sd_act));
      if (crop_size !== 10'd0) report_mismatch("reset_crop", 32'd0, 32'(crop_size));
      if (phys_sd.cs_n !== 1'b0) report_mismatch("reset_cs_n", 32'd0, 32'(phys_sd.cs_n));
      if (vsd_ss_n !== 1'b1) report_mismatch("reset_vsd_ss_n", 32'd1, 32'(vsd_ss_n));
      repeat (20) @(negedge clk21m);

      fd = $fopen("verif/msx_io_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test data file verif/msx_io_testdata.txt");
         other_errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 3) continue;
            kind = line.getc(0);
            if (kind == "#") continue;
            body = line.substr(1, line.len() - 1);
            case (kind)
               "S": begin
                  n = $sscanf(body, "%d %h %h %d", dir, tx_byte, card_byte, sel);
                  if (n == 4) run_spi(dir != 0, tx_byte, card_byte, sel != 0);
                  else n = -1;
               end
               "M": begin
                  n = $sscanf(body, "%h %d", size, sel);
                  if (n == 2) mount_image(size, sel != 0);
                  else n = -1;
               end
               "C": begin
                  n = $sscanf(body, "%d %d %d %b %d %d %d", w, h, forced, cfg, e_arx, e_ary,
                              e_crop);
                  if (n == 7) check_crop(w, h, forced != 0, cfg, e_arx, e_ary, e_crop);
                  else n = -1;
               end
               default: n = -1;
            endcase
            if (n < 0) begin
               $display("Line %0d of the test data file could not be read", line_no);
               other_errors++;
            end
         end
         $fclose(fd);
      end

      // Bus quiet now, activity drops after the hold time
      wait_cnt = 0;
      while (sd_act && wait_cnt < ACT_HOLD + 16) begin
         @(negedge clk21m);
         wait_cnt++;
      end
      if (sd_act) begin
         $display("Timeout: sd_act still high %0d cycles after the last transfer", wait_cnt);
         other_errors++;
      end else if (wait_cnt < ACT_HOLD) begin
         report_mismatch("sd_act_hold", ACT_HOLD, wait_cnt);
      end

      $display("Result: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: verif/msx_io_testdata.txt
# S (SPI): dir (1 tx, 0 rx), tx byte hex, card byte hex, card (0 physical, 1 image)
# M (mount): image size hex, expected card; C (crop): width height forced
# cfg (aspect_sel scanlines vcrop_en, binary), then expected arx ary crop_size
C 1280 720 0 00001 400 300 240
C 720 480 0 00001 400 300 240
C 1920 1200 0 00001 400 300 240
C 1024 600 0 00001 340 300 200
C 1280 800 0 00001 340 300 200
C 1024 600 0 00000 400 300 0
C 1366 768 0 00001 400 300 256
C 1920 1080 0 00001 400 300 216
C 1920 1080 1 00001 400 300 0
C 1920 1080 0 00011 400 300 0
C 1920 1440 0 00001 400 300 240
C 2048 1536 0 00001 400 300 256
C 640 480 0 00001 400 300 0
C 1024 768 0 00001 400 300 0
C 1280 720 0 01001 0 0 240
C 1024 600 0 11001 2 0 200
C 1920 1080 0 10000 1 0 0
S 1 a5 3c 0
S 0 00 c3 0
S 1 5a 96 0
M 00100000 1
S 1 0f e1 1
S 0 00 7e 1
S 1 c6 01 1
M 00000000 0
S 1 81 18 0
S 0 00 ff 0
S 1 33 55 0

// File: verilog.f
+incdir+hdl
hdl/msx_io_pkg.sv
hdl/spi_byte_engine.sv
hdl/sd_port_switch.sv
hdl/video_crop.sv
hdl/msx_io_top.sv
verif/msx_io_sva.sv
verif/msx_io_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := msx_io_tb
FILELIST := verilog.f

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
